// File: cpu_bus_pkg.sv
package cpu_bus_pkg;

	// Operation requested by a CPU port
	typedef enum logic {
		OP_READ,
		OP_WRITE
	} bus_op_t;

	typedef struct packed {
		bus_op_t     op;
		logic [31:0] addr;	// Byte address
		logic [31:0] wdata;
		logic [3:0]  sel;	// Byte lanes
	} port_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic        error;
	} port_rsp_t;

	// Wishbone classic, master to slave
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [29:0] adr;	// Word address
		logic [31:0] dat;
		logic [3:0]  sel;
	} wb_req_t;

	// Wishbone classic, slave to master
	typedef struct packed {
		logic        ack;
		logic        err;
		logic [31:0] dat;
	} wb_rsp_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUS,
		ST_DONE
	} arb_state_t;

	typedef enum logic {
		PORT_A,
		PORT_B
	} port_id_t;

endpackage

// File: mem_map_pkg.sv
package mem_map_pkg;

	// Four identical banks of 32-bit words
	localparam int NUM_BANKS  = 4;
	localparam int BANK_WORDS = 256;

	// Word address layout
	//   [WORD_IDX_W-1:0]                    word inside a bank
	//   [WORD_IDX_W+BANK_IDX_W-1:WORD_IDX_W] bank index
	localparam int BANK_IDX_W = 2;
	localparam int WORD_IDX_W = 8;

	// Mapped region starts at byte 0
	localparam int MAPPED_BYTES = 4096;
	localparam int MAPPED_WORDS = MAPPED_BYTES / 4;	// First unmapped word address

endpackage

// File: sram_bank.sv
`timescale 1ns/100ps

module sram_bank (
	input  logic                 i_clock,
	input  logic                 i_arst_n,
	input  cpu_bus_pkg::wb_req_t i_wb_req,
	output cpu_bus_pkg::wb_rsp_t o_wb_rsp
);
	import mem_map_pkg::*;

	logic [31:0]           mem [BANK_WORDS];
	logic [WORD_IDX_W-1:0] word_idx;
	logic                  access;
	logic                  ack_q;
	logic [31:0]           rdata_q;

	assign word_idx = i_wb_req.adr[WORD_IDX_W-1:0];

	// A held strobe is served once, the ack cycle is skipped
	assign access = i_wb_req.cyc && i_wb_req.stb && !ack_q;

	always_ff @(posedge i_clock) begin
		if (access && i_wb_req.we) begin
			for (int b = 0; b < 4; b++) begin
				if (i_wb_req.sel[b]) begin
					mem[word_idx][8*b +: 8] <= i_wb_req.dat[8*b +: 8];	// Byte lane write
				end
			end
		end
		rdata_q <= mem[word_idx];	// Old word on a write
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	assign o_wb_rsp = '{ack: ack_q, err: 1'b0, dat: rdata_q};

endmodule

// File: bus_decoder.sv
`timescale 1ns/100ps

module bus_decoder (
	input  logic                 i_clock,
	input  logic                 i_arst_n,

	// From the master
	input  cpu_bus_pkg::wb_req_t i_wb_req,
	output cpu_bus_pkg::wb_rsp_t o_wb_rsp,

	// To and from the banks
	output cpu_bus_pkg::wb_req_t o_bank_req [mem_map_pkg::NUM_BANKS],
	input  cpu_bus_pkg::wb_rsp_t i_bank_rsp [mem_map_pkg::NUM_BANKS]
);
	import mem_map_pkg::*;

	logic [BANK_IDX_W-1:0] bank_idx;
	logic                  mapped;
	logic                  err_q;

	assign bank_idx = i_wb_req.adr[WORD_IDX_W +: BANK_IDX_W];
	assign mapped   = (i_wb_req.adr < 30'(MAPPED_WORDS));

	// Fields go to every bank, strobes only to the selected one
	always_comb begin
		for (int i = 0; i < NUM_BANKS; i++) begin
			o_bank_req[i]     = i_wb_req;
			o_bank_req[i].cyc = i_wb_req.cyc && mapped && (bank_idx == BANK_IDX_W'(i));
			o_bank_req[i].stb = i_wb_req.stb && mapped && (bank_idx == BANK_IDX_W'(i));
		end
	end

	// Unmapped cycles are answered here, same latency as a bank
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			err_q <= 1'b0;
		end else begin
			err_q <= i_wb_req.cyc && i_wb_req.stb && !mapped && !err_q;
		end
	end

	// Return path
	always_comb begin
		if (mapped) begin
			o_wb_rsp.ack = i_bank_rsp[bank_idx].ack;
			o_wb_rsp.dat = i_bank_rsp[bank_idx].dat;
		end else begin
			o_wb_rsp.ack = 1'b0;
			o_wb_rsp.dat = '0;	// Error reads back zero
		end
		o_wb_rsp.err = err_q;
	end

endmodule

// File: cpu_bus_access.sv
`timescale 1ns/100ps

module cpu_bus_access (
	input  logic                   i_clock,
	input  logic                   i_arst_n,

	// Port A, instruction fetch
	input  logic                   i_pa_request,
	input  cpu_bus_pkg::port_req_t i_pa_req,
	output logic                   o_pa_ready,
	output cpu_bus_pkg::port_rsp_t o_pa_rsp,

	// Port B, data load and store
	input  logic                   i_pb_request,
	input  cpu_bus_pkg::port_req_t i_pb_req,
	output logic                   o_pb_ready,
	output cpu_bus_pkg::port_rsp_t o_pb_rsp,

	// Shared Wishbone master
	output cpu_bus_pkg::wb_req_t   o_wb_req,
	input  cpu_bus_pkg::wb_rsp_t   i_wb_rsp
);
	import cpu_bus_pkg::*;

	arb_state_t  state;
	port_id_t    owner;			// Port that owns the bus cycle
	port_id_t    grant_id;
	port_req_t   grant_req;
	logic        any_request;
	logic        grant;
	logic        bus_done;
	port_rsp_t   bus_rsp;
	port_rsp_t   pa_rsp_q;
	port_rsp_t   pb_rsp_q;

	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [29:0] wb_adr;
	logic [31:0] wb_dat;
	logic [3:0]  wb_sel;

	// Fixed priority, A beats B
	always_comb begin
		any_request = i_pa_request | i_pb_request;
		if (i_pa_request) begin
			grant_id  = PORT_A;
			grant_req = i_pa_req;
		end else begin
			grant_id  = PORT_B;
			grant_req = i_pb_req;
		end
	end

	assign grant    = (state == ST_IDLE) && any_request;
	assign bus_done = (state == ST_BUS) && (i_wb_rsp.ack || i_wb_rsp.err);
	assign bus_rsp  = '{rdata: i_wb_rsp.dat, error: i_wb_rsp.err};

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state  <= ST_IDLE;
			owner  <= PORT_A;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (grant) begin
						state  <= ST_BUS;
						owner  <= grant_id;
						wb_cyc <= 1'b1;	// Start classic cycle
						wb_stb <= 1'b1;
					end
				end
				ST_BUS: begin
					// Held until the slave answers
					if (bus_done) begin
						state  <= ST_DONE;
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
					end
				end
				ST_DONE: state <= ST_IDLE;	// Ready pulse cycle
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Request fields and responses
	always_ff @(posedge i_clock) begin
		if (grant) begin
			wb_we  <= (grant_req.op == OP_WRITE);
			wb_adr <= grant_req.addr[31:2];	// Drop byte offset
			wb_dat <= grant_req.wdata;
			wb_sel <= grant_req.sel;
		end
		if (bus_done) begin
			if (owner == PORT_A) begin
				pa_rsp_q <= bus_rsp;
			end else begin
				pb_rsp_q <= bus_rsp;
			end
		end
	end

	assign o_wb_req = '{
		cyc: wb_cyc,
		stb: wb_stb,
		we:  wb_we,
		adr: wb_adr,
		dat: wb_dat,
		sel: wb_sel
	};

	// One cycle of ready for the owning port only
	assign o_pa_ready = (state == ST_DONE) && (owner == PORT_A);
	assign o_pb_ready = (state == ST_DONE) && (owner == PORT_B);
	assign o_pa_rsp   = pa_rsp_q;
	assign o_pb_rsp   = pb_rsp_q;

endmodule

// File: cpu_bus_subsystem.sv
`timescale 1ns/100ps

module cpu_bus_subsystem (
	input  logic                   i_clock,
	input  logic                   i_arst_n,

	// Port A, instruction fetch
	input  logic                   i_pa_request,
	input  cpu_bus_pkg::port_req_t i_pa_req,
	output logic                   o_pa_ready,
	output cpu_bus_pkg::port_rsp_t o_pa_rsp,

	// Port B, data load and store
	input  logic                   i_pb_request,
	input  cpu_bus_pkg::port_req_t i_pb_req,
	output logic                   o_pb_ready,
	output cpu_bus_pkg::port_rsp_t o_pb_rsp
);
	import cpu_bus_pkg::*;
	import mem_map_pkg::*;

	wb_req_t wb_req;		// Shared bus
	wb_rsp_t wb_rsp;
	wb_req_t bank_req [NUM_BANKS];
	wb_rsp_t bank_rsp [NUM_BANKS];

	cpu_bus_access access_i (
		.i_clock      (i_clock),
		.i_arst_n     (i_arst_n),
		.i_pa_request (i_pa_request),
		.i_pa_req     (i_pa_req),
		.o_pa_ready   (o_pa_ready),
		.o_pa_rsp     (o_pa_rsp),
		.i_pb_request (i_pb_request),
		.i_pb_req     (i_pb_req),
		.o_pb_ready   (o_pb_ready),
		.o_pb_rsp     (o_pb_rsp),
		.o_wb_req     (wb_req),
		.i_wb_rsp     (wb_rsp)
	);

	bus_decoder decoder_i (
		.i_clock    (i_clock),
		.i_arst_n   (i_arst_n),
		.i_wb_req   (wb_req),
		.o_wb_rsp   (wb_rsp),
		.o_bank_req (bank_req),
		.i_bank_rsp (bank_rsp)
	);

	for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
		sram_bank bank_i (
			.i_clock  (i_clock),
			.i_arst_n (i_arst_n),
			.i_wb_req (bank_req[g]),
			.o_wb_rsp (bank_rsp[g])
		);
	end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
	output logic o_clock,
	output logic o_arst_n
);
	localparam int HALF_PERIOD  = 4;	// 8 ns clock
	localparam int RESET_CYCLES = 10;

	initial begin
		o_clock = 1'b0;
		forever #(HALF_PERIOD) o_clock = ~o_clock;
	end

	// Released just after an edge, like any other input
	initial begin
		o_arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clock);
		#1 o_arst_n = 1'b1;
	end

endmodule

// File: tb_cpu_bus.sv
`timescale 1ns/100ps

module tb_cpu_bus;
	import cpu_bus_pkg::*;
	import mem_map_pkg::*;

	localparam int WORD_ADDR_W     = BANK_IDX_W + WORD_IDX_W;
	localparam int NUM_TRANS       = 57;
	localparam int WATCHDOG_CYCLES = NUM_TRANS * 4 + 200;

	// Same names as the DUT ports
	logic      i_clock;
	logic      i_arst_n;
	logic      i_pa_request;
	port_req_t i_pa_req;
	logic      o_pa_ready;
	port_rsp_t o_pa_rsp;
	logic      i_pb_request;
	port_req_t i_pb_req;
	logic      o_pb_ready;
	port_rsp_t o_pb_rsp;

	logic [31:0] shadow [MAPPED_WORDS] = '{default: '0};
	logic [31:0] shadow_mask [MAPPED_WORDS] = '{default: '0};	// Bits written so far
	logic [31:0] lfsr_state = 32'h434b;
	logic [31:0] bank_addr [NUM_BANKS];
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          errors_before = 0;

	tb_clock_gen clock_gen_i (.o_clock(i_clock), .o_arst_n(i_arst_n));

	cpu_bus_subsystem dut_i (.*);

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic check(input logic ok, input string msg);
		checks++;
		assert (ok) else report_mismatch(msg);
	endtask

	// Ready is a one-cycle pulse for one port at a time
	a_ready_pulse: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		(o_pa_ready || o_pb_ready) |=> !(o_pa_ready || o_pb_ready))
		else report_mismatch("ready high for two cycles in a row");
	a_ready_one_port: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		!(o_pa_ready && o_pb_ready)) else report_mismatch("both ready outputs high");
	// No ready without a request behind it
	a_ready_a_cause: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		$rose(o_pa_ready) |-> $past(i_pa_request, 2))
		else report_mismatch("port A ready without a request");
	a_ready_b_cause: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		$rose(o_pb_ready) |-> $past(i_pb_request, 2))
		else report_mismatch("port B ready without a request");

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	function automatic logic [31:0] random_addr(input logic [BANK_IDX_W-1:0] bank, input int bits);
		logic [WORD_IDX_W-1:0] word;
		word = WORD_IDX_W'(random_bits(bits));
		return 32'({bank, word, 2'b00});
	endfunction

	// Writes only the sel byte lanes of mapped words
	function automatic void shadow_write(input port_req_t req);
		logic [WORD_ADDR_W-1:0] idx;
		idx = req.addr[2 +: WORD_ADDR_W];
		if (req.op == OP_WRITE && req.addr < 32'(MAPPED_BYTES)) begin
			for (int b = 0; b < 4; b++) begin
				if (req.sel[b]) begin
					shadow[idx][8*b +: 8]      = req.wdata[8*b +: 8];
					shadow_mask[idx][8*b +: 8] = 8'hff;
				end
			end
		end
	endfunction

	task automatic drive_port_a(input port_req_t req, output port_rsp_t rsp, output int cycles);
		@(posedge i_clock);
		#1;
		i_pa_request = 1'b1;
		i_pa_req     = req;
		cycles       = 0;
		do begin
			@(posedge i_clock);
			#1;
			cycles++;
		end while (!o_pa_ready);
		rsp          = o_pa_rsp;
		i_pa_request = 1'b0;	// Low before the next edge
	endtask

	task automatic drive_port_b(input port_req_t req, output port_rsp_t rsp, output int cycles);
		@(posedge i_clock);
		#1;
		i_pb_request = 1'b1;
		i_pb_req     = req;
		cycles       = 0;
		do begin
			@(posedge i_clock);
			#1;
			cycles++;
		end while (!o_pb_ready);
		rsp          = o_pb_rsp;
		i_pb_request = 1'b0;
	endtask

	// One transaction checked against the shadow memory
	task automatic transfer(input port_id_t port, input port_req_t req, input int latency,
			output int cycles);
		port_rsp_t              rsp;
		logic                   mapped;
		logic [WORD_ADDR_W-1:0] idx;
		mapped = req.addr < 32'(MAPPED_BYTES);
		idx    = req.addr[2 +: WORD_ADDR_W];
		if (port == PORT_A) begin
			drive_port_a(req, rsp, cycles);
		end else begin
			drive_port_b(req, rsp, cycles);
		end
		check(cycles == latency, $sformatf("latency %0d, expected %0d", cycles, latency));
		check(rsp.error == !mapped, $sformatf("error %b at address %h", rsp.error, req.addr));
		if (!mapped) begin
			check(rsp.rdata == '0, $sformatf("unmapped rdata %h, expected 0", rsp.rdata));
		end else if (req.op == OP_READ) begin
			check((rsp.rdata & shadow_mask[idx]) == (shadow[idx] & shadow_mask[idx]),
				$sformatf("read %h got %h, expected %h", req.addr, rsp.rdata, shadow[idx]));
		end
		shadow_write(req);
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("Test %0d %s: %0d errors", tests, name, errors - errors_before);
		errors_before = errors;
	endtask

	initial begin
		port_req_t   req;
		port_req_t   req_b;
		int          cycles;
		int          cycles_b;
		logic [31:0] pick;
		i_pa_request = 1'b0;
		i_pa_req     = '0;
		i_pb_request = 1'b0;
		i_pb_req     = '0;
		wait (i_arst_n === 1'b1);

		repeat (5) begin
			@(posedge i_clock);
			#1;
			check(!o_pa_ready && !o_pb_ready, "ready high with no request after reset");
		end
		end_test("idle after reset");

		for (int b = 0; b < NUM_BANKS; b++) begin
			bank_addr[b] = random_addr(2'(b), WORD_IDX_W);
			req = '{op: OP_WRITE, addr: bank_addr[b], wdata: random_bits(32), sel: 4'hf};
			transfer(PORT_B, req, 3, cycles);
			req.op = OP_READ;
			transfer(PORT_A, req, 3, cycles);
		end
		end_test("write and read in each bank");

		req = '{op: OP_WRITE, addr: random_addr(2'd1, WORD_IDX_W), wdata: random_bits(32),
			sel: 4'hf};
		transfer(PORT_B, req, 3, cycles);
		req.wdata = ~req.wdata;
		req.sel   = 4'b0110;	// Middle lanes only
		transfer(PORT_B, req, 3, cycles);
		req.op = OP_READ;
		transfer(PORT_B, req, 3, cycles);
		end_test("partial byte select");

		req = '{op: OP_WRITE, addr: random_addr(2'd2, WORD_IDX_W), wdata: random_bits(32),
			sel: 4'hf};
		transfer(PORT_B, req, 3, cycles);
		req.addr  = req.addr + 32'(MAPPED_BYTES);	// Same low bits but off the map
		req.wdata = ~req.wdata;
		transfer(PORT_B, req, 3, cycles);
		req.op = OP_READ;
		transfer(PORT_A, req, 3, cycles);
		req.addr = req.addr - 32'(MAPPED_BYTES);
		transfer(PORT_A, req, 3, cycles);
		end_test("unmapped address");

		// A wins and B follows one transaction later
		req   = '{op: OP_READ, addr: bank_addr[0], wdata: '0, sel: 4'hf};
		req_b = '{op: OP_READ, addr: bank_addr[3], wdata: '0, sel: 4'hf};
		fork
			transfer(PORT_A, req, 3, cycles);
			transfer(PORT_B, req_b, 7, cycles_b);
		join
		check(cycles_b - cycles == 4, "port B ready not 4 cycles after port A");
		end_test("both ports at once");

		for (int n = 0; n < 40; n++) begin
			pick      = random_bits(5);
			req.op    = pick[0] ? OP_WRITE : OP_READ;
			req.addr  = random_addr(BANK_IDX_W'(random_bits(BANK_IDX_W)), 4);	// 16 words a bank
			req.wdata = random_bits(32);
			req.sel   = 4'(random_bits(4));
			if (pick[4:2] == 3'd0) begin
				req.addr = req.addr + 32'(MAPPED_BYTES);
			end
			transfer(pick[1] ? PORT_B : PORT_A, req, 3, cycles);
		end
		end_test("random mix");

		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clock);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: files.f
cpu_bus_pkg.sv
mem_map_pkg.sv
sram_bank.sv
bus_decoder.sv
cpu_bus_access.sv
cpu_bus_subsystem.sv
tb_clock_gen.sv
tb_cpu_bus.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run tb_cpu_bus with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_cpu_bus -f files.f
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

output="$(./obj_dir/Vtb_cpu_bus)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
	exit 0
fi
exit 1
